/* Bender.yml */
package:
  name: stream_arb

sources:
  # Design
  - files:
      - source/stream_arb_pkg.sv
      - source/port_fifo.sv
      - source/rr_arbiter.sv
      - source/out_stage.sv
      - source/stream_arb_top.sv

  # Verification
  - target: test
    files:
      - tb/stream_arb_assert.sv
      - tb/stream_arb_tb.sv

/* flist.f */
source/stream_arb_pkg.sv
source/port_fifo.sv
source/rr_arbiter.sv
source/out_stage.sv
source/stream_arb_top.sv
tb/stream_arb_assert.sv
tb/stream_arb_tb.sv

/* tb/stream_arb_tb.sv */
`timescale 1ns/1ps

module stream_arb_tb
    import stream_arb_pkg::*;
();

    logic        clk;
    logic        rst;
    port_vec_t   in_valid;
    data_t       in_data [NUM_PORTS];
    port_vec_t   in_ready;
    logic        out_valid;
    logic        out_ready;
    data_t       out_data;
    port_id_t    out_port;

    // Scoreboard results read by the checker.
    logic        exp_found;
    data_t       exp_data;
    logic        rr_check;
    logic        stream_check;
    logic        end_check;
    logic        queues_empty;

    int          fail_count = 0;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic [31:0] rng_state;
    port_vec_t   moved_in;
    logic [12:0] seq [NUM_PORTS];
    data_t       exp_q [NUM_PORTS][$];

    stream_arb_top i_dut
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_port  (out_port)
    );

    bind stream_arb_top stream_arb_assert i_assert
    (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .out_port     (out_port),
        .avail        (avail),
        .gnt          (gnt),
        .load         (load),
        .exp_found    (stream_arb_tb.exp_found),
        .exp_data     (stream_arb_tb.exp_data),
        .rr_check     (stream_arb_tb.rr_check),
        .stream_check (stream_arb_tb.stream_check),
        .end_check    (stream_arb_tb.end_check),
        .queues_empty (stream_arb_tb.queues_empty)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // About twice the length of all tests together.
    initial
    begin
        cycle_count = 0;
        while (cycle_count < 4000)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the tests did not finish.", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pending_words();
        int total;
        total = 0;
        for (int i = 0; i < NUM_PORTS; i++)
            total += exp_q[i].size();
        return total;
    endfunction

    // Drive one cycle, then log what the coming edge will move.
    task automatic step(input port_vec_t want, input logic ready);
        port_id_t p;
        @(posedge clk);
        #10;
        // An offered word stays up until its FIFO takes it.
        in_valid  = (in_valid & ~moved_in) | want;
        out_ready = ready;
        end_check = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++)
            in_data[i] = {port_id_t'(i), seq[i]};
        exp_found = 1'b0;
        if (out_valid && out_ready)
        begin
            p = out_port;
            if (exp_q[p].size() != 0)
            begin
                exp_found = 1'b1;
                exp_data  = exp_q[p].pop_front();
            end
        end
        moved_in = in_valid & in_ready;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (moved_in[i])
            begin
                exp_q[i].push_back(in_data[i]);
                seq[i] = seq[i] + 1'b1;
            end
        end
    endtask

    // Drain every FIFO, then have the checker look at the scoreboard.
    task automatic finish_test(input string name, input int fails_before);
        int n;
        n = 0;
        while ((pending_words() != 0 || in_valid != '0 || out_valid) && n < 200)
        begin
            step('0, 1'b1);
            n++;
        end
        queues_empty = (pending_words() == 0);
        end_check    = 1'b1;
        step('0, 1'b1);
        step('0, 1'b1);
        tests_run++;
        if (fail_count != fails_before)
            tests_failed++;
        $display("Test %s done with %0d failed checks.", name, fail_count - fails_before);
    endtask

    initial
    begin
        int          fails_before;
        int          n;
        port_vec_t   want;

        rng_state    = 32'h38e7;
        rst          = 1'b1;
        in_valid     = '0;
        out_ready    = 1'b0;
        moved_in     = '0;
        exp_found    = 1'b0;
        exp_data     = '0;
        rr_check     = 1'b0;
        stream_check = 1'b0;
        end_check    = 1'b0;
        queues_empty = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            in_data[i] = '0;
            seq[i]     = '0;
        end

        fails_before = fail_count;
        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (3) step('0, 1'b1);
        finish_test("reset", fails_before);

        // About one word offered per cycle against a sink ready three cycles in four.
        fails_before = fail_count;
        for (int c = 0; c < 1000; c++)
        begin
            rng_state = xorshift32(rng_state);
            want = rng_state[7:0] & rng_state[15:8] & rng_state[23:16];
            step(want, rng_state[25:24] != 2'b00);
        end
        finish_test("random traffic", fails_before);

        fails_before = fail_count;
        for (int c = 0; c < 250; c++)
        begin
            rr_check     = (c >= 12);
            stream_check = (c >= 12);
            step('1, 1'b1);
        end
        rr_check     = 1'b0;
        stream_check = 1'b0;
        finish_test("fairness", fails_before);

        // Park one word in the output register, then flood all ports.
        fails_before = fail_count;
        step(8'h01, 1'b0);
        n = 0;
        while (!out_valid && n < 20)
        begin
            step('0, 1'b0);
            n++;
        end
        for (int c = 0; c < 60; c++)
            step('1, c >= 40);
        finish_test("back-pressure", fails_before);

        fails_before = fail_count;
        for (int c = 0; c < 120; c++)
        begin
            stream_check = (c >= 8);
            step(8'h20, 1'b1);
        end
        stream_check = 1'b0;
        // Sparse words, so the FIFO mostly holds just one.
        for (int c = 0; c < 120; c++)
        begin
            rng_state = xorshift32(rng_state);
            want      = '0;
            want[2]   = (rng_state[2:0] == 3'd0);
            step(want, 1'b1);
        end
        finish_test("single requester", fails_before);

        $display("Tests run %0d, tests failed %0d, failed checks %0d.",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* tb/stream_arb_assert.sv */
`timescale 1ns/1ps

module stream_arb_assert
    import stream_arb_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input port_vec_t in_valid,
    input port_vec_t in_ready,
    input logic      out_valid,
    input logic      out_ready,
    input data_t     out_data,
    input port_id_t  out_port,
    input port_vec_t avail,
    input port_vec_t gnt,
    input logic      load,
    input logic      exp_found,
    input data_t     exp_data,
    input logic      rr_check,
    input logic      stream_check,
    input logic      end_check,
    input logic      queues_empty
);

    logic [3:0] skip_cnt [NUM_PORTS];
    data_t      held_data;
    port_id_t   held_port;
    port_id_t   next_port;

    // Output as it was one edge earlier.
    always_ff @(posedge clk)
    begin
        held_data <= out_data;
        held_port <= out_port;
    end

    assign next_port = held_port + 3'd1;

    // Grants consumed by other ports while this one had a word on offer.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_PORTS; i++)
                skip_cnt[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_PORTS; i++)
            begin
                if (!avail[i] || (load && gnt[i]))
                    skip_cnt[i] <= '0;
                else if (load)
                    skip_cnt[i] <= skip_cnt[i] + 1'b1;
            end
        end
    end

    a_reset_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else
        begin
            $error("ERR %0t out_valid exp 0 got %b", $time, $sampled(out_valid));
            stream_arb_tb.fail_count += 1;
        end

    a_reset_ready: assert property (@(posedge clk) rst |=> in_ready == '1)
        else
        begin
            $error("ERR %0t in_ready exp ff got %h", $time, $sampled(in_ready));
            stream_arb_tb.fail_count += 1;
        end

    a_pending: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> exp_found)
        else
        begin
            $error("Port %0d sent a word with none pending from that port.",
                   $sampled(out_port));
            stream_arb_tb.fail_count += 1;
        end

    a_order: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && exp_found |-> out_data == exp_data)
        else
        begin
            $error("ERR %0t out_data exp %h got %h", $time,
                   $sampled(exp_data), $sampled(out_data));
            stream_arb_tb.fail_count += 1;
        end

    // Every word carries its source port in the top bits.
    a_tag: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_data[15:13] == out_port)
        else
        begin
            $error("ERR %0t out_port exp %0d got %0d", $time,
                   $sampled(out_data[15:13]), $sampled(out_port));
            stream_arb_tb.fail_count += 1;
        end

    a_hold_data: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_data == held_data)
        else
        begin
            $error("ERR %0t out_data exp %h got %h", $time,
                   $sampled(held_data), $sampled(out_data));
            stream_arb_tb.fail_count += 1;
        end

    a_hold_port: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_port == held_port)
        else
        begin
            $error("ERR %0t out_port exp %0d got %0d", $time,
                   $sampled(held_port), $sampled(out_port));
            stream_arb_tb.fail_count += 1;
        end

    // All ports busy, so each transfer follows the one before.
    a_round_robin: assert property (@(posedge clk) disable iff (rst)
        rr_check && $past(rr_check) && $past(out_valid && out_ready)
            && out_valid && out_ready |-> out_port == next_port)
        else
        begin
            $error("ERR %0t out_port exp %0d got %0d", $time,
                   $sampled(next_port), $sampled(out_port));
            stream_arb_tb.fail_count += 1;
        end

    // Continuous demand and a ready sink give one word per cycle.
    a_stream: assert property (@(posedge clk) disable iff (rst)
        stream_check |-> out_valid)
        else
        begin
            $error("ERR %0t out_valid exp 1 got %b", $time, $sampled(out_valid));
            stream_arb_tb.fail_count += 1;
        end

    a_drained: assert property (@(posedge clk) disable iff (rst)
        end_check |-> queues_empty)
        else
        begin
            $error("Words were still pending at the end of a test.");
            stream_arb_tb.fail_count += 1;
        end

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port_chk
        a_fair: assert property (@(posedge clk) disable iff (rst)
            skip_cnt[i] <= 4'd7)
            else
            begin
                $error("Port %0d was passed over eight times in a row.", i);
                stream_arb_tb.fail_count += 1;
            end

        a_fill: assert property (@(posedge clk) disable iff (rst)
            (out_valid && !out_ready && in_valid[i] && in_ready[i]) [*FIFO_DEPTH]
                ##1 (out_valid && !out_ready) |-> !in_ready[i])
            else
            begin
                $error("Port %0d stayed ready after filling its FIFO in a stall.", i);
                stream_arb_tb.fail_count += 1;
            end

        a_full: assert property (@(posedge clk) disable iff (rst)
            out_valid && !out_ready && !in_ready[i]
                ##1 (out_valid && !out_ready) |-> !in_ready[i])
            else
            begin
                $error("Port %0d became ready again during a stall.", i);
                stream_arb_tb.fail_count += 1;
            end
    end

endmodule

/* source/stream_arb_top.sv */
`timescale 1ns/1ps

module stream_arb_top
    import stream_arb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  port_vec_t in_valid,
    input  data_t     in_data [NUM_PORTS],
    output port_vec_t in_ready,
    output logic      out_valid,
    input  logic      out_ready,
    output data_t     out_data,
    output port_id_t  out_port
);

    port_vec_t avail;
    port_vec_t gnt;
    port_vec_t pop;
    logic      stall;
    logic      load;
    data_t     heads [NUM_PORTS];
    data_t     load_data;
    port_id_t  load_port;

    for (genvar i = 0; i < NUM_PORTS; i++)
    begin : g_port
        port_fifo i_fifo
        (
            .clk      (clk),
            .rst      (rst),
            .wr_valid (in_valid[i]),
            .wr_ready (in_ready[i]),
            .wr_data  (in_data[i]),
            .pop      (pop[i]),
            .head     (heads[i]),
            .avail    (avail[i])
        );
    end

    rr_arbiter i_arbiter
    (
        .clk   (clk),
        .rst   (rst),
        .req   (avail),
        .stall (stall),
        .gnt   (gnt)
    );

    // Nothing moves while the output register is blocked.
    assign pop  = stall ? '0 : gnt;
    assign load = (gnt != '0) && !stall;

    // Grant is one-hot, so an OR of the masked heads is the mux.
    always_comb
    begin
        load_data = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (gnt[i])
                load_data = load_data | heads[i];
        end
    end

    assign load_port = onehot_to_id(gnt);

    out_stage i_out
    (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .load_data (load_data),
        .load_port (load_port),
        .stall     (stall),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_port  (out_port)
    );

endmodule

/* source/out_stage.sv */
`timescale 1ns/1ps

module out_stage
    import stream_arb_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  data_t    load_data,
    input  port_id_t load_port,
    output logic     stall,
    output logic     out_valid,
    input  logic     out_ready,
    output data_t    out_data,
    output port_id_t out_port
);

    logic     valid_q;
    data_t    data_q;
    port_id_t port_q;

    // Full and not draining.
    assign stall = valid_q && !out_ready;

    assign out_valid = valid_q;
    assign out_data  = data_q;
    assign out_port  = port_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            valid_q <= 1'b0;
        else if (load)
            valid_q <= 1'b1;
        else if (out_ready)
            valid_q <= 1'b0;
    end

    // Load only comes when the register is empty or draining.
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            data_q <= load_data;
            port_q <= load_port;
        end
    end

endmodule

/* source/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter
    import stream_arb_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  port_vec_t req,
    input  logic      stall,
    output port_vec_t gnt
);

    port_id_t  ptr;
    port_id_t  ptr_next;
    port_vec_t shift_req;
    port_vec_t shift_gnt;
    port_vec_t d_gnt;
    logic      consume;

    // A grant is used up when it is live and the output can take it.
    assign consume = (gnt != '0) && !stall;

    // Start the search one past the port served in this cycle.
    always_comb
    begin
        if (consume)
            ptr_next = onehot_to_id(gnt) + 3'd1;
        else
            ptr_next = ptr;
    end

    // Rotate so that the pointer position sits at bit zero.
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            shift_req[i] = req[(i + ptr_next) % NUM_PORTS];
        end
    end

    // Lowest set bit wins.
    assign shift_gnt = shift_req & (~shift_req + 1'b1);

    // Rotate the pick back to port order.
    always_comb
    begin
        d_gnt = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            d_gnt[(i + ptr_next) % NUM_PORTS] = shift_gnt[i];
        end
    end

    // Grant holds while the output is stalled.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            gnt <= '0;
        else if (!stall)
            gnt <= d_gnt;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            ptr <= '0;
        else if (!stall)
            ptr <= ptr_next;
    end

endmodule

/* source/port_fifo.sv */
`timescale 1ns/1ps

module port_fifo
    import stream_arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_valid,
    output logic  wr_ready,
    input  data_t wr_data,
    input  logic  pop,
    output data_t head,
    output logic  avail
);

    data_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic [FIFO_PTR_W:0]   ready_cnt;
    logic                  push;
    logic                  fresh;

    assign wr_ready = (count < FIFO_DEPTH);
    assign push     = wr_valid && wr_ready;
    assign head     = mem[rd_ptr];

    // A word written on the last edge is not offered yet.
    assign ready_cnt = fresh ? count - 1'b1 : count;

    // Hide the last offered word while it is being popped.
    always_comb
    begin
        if (pop)
            avail = (ready_cnt > 1);
        else
            avail = (ready_cnt != 0);
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else
        begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            fresh <= 1'b0;
        else
            fresh <= push;
    end

endmodule

/* source/stream_arb_pkg.sv */
package stream_arb_pkg;

    localparam int NUM_PORTS  = 8;
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Payload word.
    typedef logic [15:0] data_t;

    // Port number, also the arbiter pointer.
    typedef logic [2:0] port_id_t;

    // One bit per port.
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // Port number of a one-hot vector, zero when the vector is empty.
    function automatic port_id_t onehot_to_id(port_vec_t vec);
        port_id_t id;
        id = '0;
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            if (vec[i])
                id = port_id_t'(i);
        end
        return id;
    endfunction

endpackage
